// File: Bender.yml
package:
  name: la_core

sources:
  - logic/core_pkg.sv
  - logic/register_file.sv
  - logic/unified_memory.sv
  - logic/mem_arbiter.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/core_top.sv
  - target: test
    files:
      - verification/core_tb.sv

// File: logic/core_pkg.sv
package core_pkg;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_addi,
        op_ld,
        op_st,
        op_beq,
        op_bne,
        op_break,
        op_nop
    } op_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } if_id_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        op_e         op;
        logic [31:0] src1;
        logic [31:0] src2;   // rk for alu ops, rd for store and branch
        logic [31:0] imm;
        logic [4:0]  rd;
        logic        we;
    } id_ex_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        op_e         op;
        logic [31:0] alu;     // result or byte address
        logic [31:0] st_data;
        logic [4:0]  rd;
        logic        we;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] value;
        logic        is_load; // value not there yet
    } fwd_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        wreg_en;
        logic [4:0]  wreg_idx;
        logic [31:0] wdata;
        logic        is_break;
    } commit_t;

    typedef struct packed {
        logic [31:0] addr;    // word address
        logic [31:0] wdata;
        logic        we;
    } mem_req_t;

endpackage

// File: logic/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; #(
    parameter int          mem_words = 1024,
    parameter logic [31:0] reset_pc  = 32'h0
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        run,
    input  logic        host_we,
    input  logic [31:0] host_addr,
    input  logic [31:0] host_wdata,
    output commit_t     commit,
    output logic        commit_valid,
    output logic        halted
);
    if_id_t      if_out;
    logic        if_valid;
    logic        if_ready;
    id_ex_t      id_out;
    logic        id_valid;
    logic        id_ready;
    ex_mem_t     ex_out;
    logic        ex_valid;
    logic        ex_ready;
    logic [4:0]  rs1_idx;
    logic [4:0]  rs2_idx;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    fwd_t        fwd_ex;
    fwd_t        fwd_mem;
    logic        flush;
    logic [31:0] redirect_pc;
    logic        inst_req;
    logic        inst_gnt;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        data_req;
    logic        data_gnt;
    logic        data_we;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;
    logic        wb_en;
    logic [4:0]  wb_idx;
    logic [31:0] wb_data;
    mem_req_t    mem_req;
    logic        mem_en;
    logic [31:0] mem_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            halted <= 1'b0;
        else if (commit_valid && commit.is_break)
            halted <= 1'b1;
    end

    fetch_stage #(.reset_pc(reset_pc)) u_fetch (
        .clk, .arst_n,
        .enable(run && !halted),    // frozen once break retires
        .inst_req, .inst_addr, .inst_gnt, .inst_rdata,
        .flush, .redirect_pc,
        .out_valid(if_valid), .out_ready(if_ready), .out(if_out)
    );

    decode_stage u_decode (
        .clk, .arst_n,
        .in_valid(if_valid), .in_ready(if_ready), .in(if_out),
        .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .fwd_ex, .fwd_mem, .flush,
        .out_valid(id_valid), .out_ready(id_ready), .out(id_out)
    );

    execute_stage u_execute (
        .clk, .arst_n,
        .in_valid(id_valid), .in_ready(id_ready), .in(id_out),
        .out_valid(ex_valid), .out_ready(ex_ready), .out(ex_out),
        .fwd_ex, .flush, .redirect_pc
    );

    memory_stage u_memory (
        .clk, .arst_n,
        .in_valid(ex_valid), .in_ready(ex_ready), .in(ex_out),
        .data_req, .data_addr, .data_wdata, .data_we, .data_gnt, .data_rdata,
        .fwd_mem, .wb_en, .wb_idx, .wb_data, .commit, .commit_valid
    );

    register_file u_regs (
        .clk, .arst_n, .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .wb_en, .wb_idx, .wb_data
    );

    mem_arbiter #(.mem_words(mem_words)) u_arbiter (
        .clk, .arst_n,
        .host_we(host_we && !run), .host_addr, .host_wdata,   // preload only while idle
        .data_req, .data_addr, .data_wdata, .data_we, .data_gnt,
        .inst_req, .inst_addr, .inst_gnt,
        .mem_req, .mem_en, .mem_rdata, .data_rdata, .inst_rdata
    );

    unified_memory #(.mem_words(mem_words)) u_memory_array (
        .clk, .mem_en, .mem_req, .rdata(mem_rdata)
    );

    // everything younger than the break is held in decode and fetch
    assert property (@(posedge clk) disable iff (!arst_n) halted |-> !commit_valid);

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    output logic        in_ready,
    input  if_id_t      in,
    output logic [4:0]  rs1_idx,
    output logic [4:0]  rs2_idx,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  fwd_t        fwd_ex,
    input  fwd_t        fwd_mem,
    input  logic        flush,
    output logic        out_valid,
    input  logic        out_ready,
    output id_ex_t      out
);
    logic [31:0] inst;
    op_e         op;
    logic [31:0] imm;
    logic        we;
    logic        use_rs1;
    logic        use_rs2;
    logic [31:0] src1;
    logic [31:0] src2;
    logic        stall;

    function automatic logic hit(input fwd_t f, input logic [4:0] idx);
        return f.valid && (f.rd == idx) && (idx != 5'd0);
    endfunction

    // youngest producer first, register file last
    function automatic logic [31:0] operand(input logic [4:0] idx, input logic [31:0] rf,
                                            input fwd_t ex, input fwd_t mem);
        if (hit(ex, idx))
            return ex.value;
        if (hit(mem, idx))
            return mem.value;
        return rf;
    endfunction

    function automatic logic load_busy(input logic [4:0] idx, input fwd_t ex, input fwd_t mem);
        if (hit(ex, idx))
            return ex.is_load;
        return hit(mem, idx) && mem.is_load;
    endfunction

    assign inst = in.inst;

    always_comb begin
        op      = op_nop;
        imm     = '0;
        we      = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        if (inst[31:15] == 17'h00020 || inst[31:15] == 17'h00022) begin
            op      = inst[16] ? op_sub : op_add;   // add.w / sub.w
            we      = 1'b1;
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
        end else if (inst[31:22] == 10'h00a || inst[31:22] == 10'h0a2) begin
            op      = inst[29] ? op_ld : op_addi;
            imm     = {{20{inst[21]}}, inst[21:10]};
            we      = 1'b1;
            use_rs1 = 1'b1;
        end else if (inst[31:22] == 10'h0a6) begin
            op      = op_st;
            imm     = {{20{inst[21]}}, inst[21:10]};
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
        end else if (inst[31:27] == 5'b01011) begin
            op      = inst[26] ? op_bne : op_beq;
            imm     = {{14{inst[25]}}, inst[25:10], 2'b00};
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
        end else if (inst[31:15] == 17'h00054) begin
            op = op_break;
        end
    end

    assign rs1_idx = inst[9:5];
    assign rs2_idx = (op == op_add || op == op_sub) ? inst[14:10] : inst[4:0];
    assign src1    = operand(rs1_idx, rs1_data, fwd_ex, fwd_mem);
    assign src2    = operand(rs2_idx, rs2_data, fwd_ex, fwd_mem);

    // load-use waits until the load data is on fwd_mem
    assign stall = in_valid && ((use_rs1 && load_busy(rs1_idx, fwd_ex, fwd_mem)) ||
                                (use_rs2 && load_busy(rs2_idx, fwd_ex, fwd_mem)));
    assign in_ready = (!out_valid || out_ready) && !stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            out_valid <= 1'b0;
        else if (flush)
            out_valid <= 1'b0;        // wrong-path instruction dropped
        else if (!out_valid || out_ready)
            out_valid <= in_valid && !stall;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            out <= '{pc: in.pc, inst: inst, op: op, src1: src1, src2: src2,
                     imm: imm, rd: inst[4:0], we: we};
    end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    output logic        in_ready,
    input  id_ex_t      in,
    output logic        out_valid,
    input  logic        out_ready,
    output ex_mem_t     out,
    output fwd_t        fwd_ex,
    output logic        flush,
    output logic [31:0] redirect_pc
);
    logic [31:0] alu;
    logic        taken;
    logic        accept;
    logic        stopped;   // younger work stays out once break has gone through

    always_comb begin
        case (in.op)
            op_add:                alu = in.src1 + in.src2;
            op_sub:                alu = in.src1 - in.src2;
            op_addi, op_ld, op_st: alu = in.src1 + in.imm;   // address sum for memory ops
            default:               alu = in.pc + 32'd4;
        endcase
    end

    assign taken = (in.op == op_beq && in.src1 == in.src2) ||
                   (in.op == op_bne && in.src1 != in.src2);

    assign in_ready    = !stopped && (!out_valid || out_ready);
    assign accept      = in_valid && in_ready;
    assign flush       = accept && taken;
    assign redirect_pc = in.pc + in.imm;
    assign fwd_ex      = '{valid: in_valid && in.we, rd: in.rd, value: alu,
                           is_load: in.op == op_ld};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            stopped   <= 1'b0;
        end else begin
            if (!out_valid || out_ready)
                out_valid <= in_valid && !stopped;
            if (accept && in.op == op_break)
                stopped <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            out <= '{pc: in.pc, inst: in.inst, op: in.op, alu: alu, st_data: in.src2,
                     rd: in.rd, we: in.we};
    end

    // decode is emptied by the flush so no wrong-path instruction follows
    assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !in_valid);

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import core_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        enable,
    output logic        inst_req,
    output logic [31:0] inst_addr,
    input  logic        inst_gnt,
    input  logic [31:0] inst_rdata,
    input  logic        flush,
    input  logic [31:0] redirect_pc,
    output logic        out_valid,
    input  logic        out_ready,
    output if_id_t      out
);
    logic [31:0] pc;
    logic [31:0] resp_pc;   // pc of the word now on inst_rdata
    logic        pending;
    logic        slot_valid;
    if_id_t      slot;
    logic        take;
    logic        slot_next;

    // a fresh response is shown directly until the slot has to hold it
    assign out_valid = slot_valid || pending;
    assign out       = slot_valid ? slot : if_id_t'{pc: resp_pc, inst: inst_rdata};
    assign take      = out_valid && out_ready;

    // the next response must find the slot empty after this edge
    assign slot_next = !flush && ((slot_valid && pending) || (out_valid && !take));
    assign inst_req  = enable && !flush && !slot_next;
    assign inst_addr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc         <= reset_pc;
            pending    <= 1'b0;
            slot_valid <= 1'b0;
        end else begin
            pending    <= inst_gnt;   // flush cycle never has a grant
            slot_valid <= slot_next;
            if (flush)
                pc <= redirect_pc;
            else if (inst_gnt)
                pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_gnt)
            resp_pc <= pc;
        if (pending && (slot_valid ? take : !take))
            slot <= '{pc: resp_pc, inst: inst_rdata};
    end

    // a response with nowhere to go would be lost
    assert property (@(posedge clk) disable iff (!arst_n)
        pending |-> !slot_valid);

endmodule

// File: logic/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import core_pkg::*; #(
    parameter int mem_words = 1024
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        host_we,
    input  logic [31:0] host_addr,
    input  logic [31:0] host_wdata,
    input  logic        data_req,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    input  logic        data_we,
    output logic        data_gnt,
    input  logic        inst_req,
    input  logic [31:0] inst_addr,
    output logic        inst_gnt,
    output mem_req_t    mem_req,
    output logic        mem_en,
    input  logic [31:0] mem_rdata,
    output logic [31:0] data_rdata,
    output logic [31:0] inst_rdata
);
    localparam int aw = $clog2(mem_words);

    logic data_own_q;   // last cycle's read belongs to the data port
    logic inst_own_q;

    function automatic logic [31:0] word_addr(input logic [31:0] byte_addr);
        return 32'(byte_addr[aw+1:2]);
    endfunction

    // host, then data, then instruction
    assign data_gnt = data_req && !host_we;
    assign inst_gnt = inst_req && !host_we && !data_req;
    assign mem_en   = host_we || data_req || inst_req;

    always_comb begin
        if (host_we)
            mem_req = '{addr: word_addr(host_addr), wdata: host_wdata, we: 1'b1};
        else if (data_req)
            mem_req = '{addr: word_addr(data_addr), wdata: data_wdata, we: data_we};
        else
            mem_req = '{addr: word_addr(inst_addr), wdata: '0, we: 1'b0};
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_own_q <= 1'b0;
            inst_own_q <= 1'b0;
        end else begin
            data_own_q <= data_gnt && !data_we;
            inst_own_q <= inst_gnt;
        end
    end

    assign data_rdata = data_own_q ? mem_rdata : '0;
    assign inst_rdata = inst_own_q ? mem_rdata : '0;

    // the host port is only driven while the core is idle
    assert property (@(posedge clk) disable iff (!arst_n)
        host_we |-> !(data_req || inst_req));

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import core_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    output logic        in_ready,
    input  ex_mem_t     in,
    output logic        data_req,
    output logic [31:0] data_addr,
    output logic [31:0] data_wdata,
    output logic        data_we,
    input  logic        data_gnt,
    input  logic [31:0] data_rdata,
    output fwd_t        fwd_mem,
    output logic        wb_en,
    output logic [4:0]  wb_idx,
    output logic [31:0] wb_data,
    output commit_t     commit,
    output logic        commit_valid
);
    logic        is_ld;
    logic        is_st;
    logic        load_wait;   // data of the granted load arrives this cycle
    logic        done;
    logic [31:0] result;

    assign is_ld = in.op == op_ld;
    assign is_st = in.op == op_st;

    assign data_req   = in_valid && (is_st || (is_ld && !load_wait));
    assign data_addr  = in.alu;
    assign data_wdata = in.st_data;
    assign data_we    = is_st;

    assign done     = in_valid && (is_st ? data_gnt : (is_ld ? load_wait : 1'b1));
    assign in_ready = !in_valid || done;
    assign result   = is_ld ? data_rdata : in.alu;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            load_wait <= 1'b0;
        else
            load_wait <= data_gnt && is_ld;
    end

    assign fwd_mem = '{valid: in_valid && in.we, rd: in.rd, value: result,
                       is_load: is_ld && !load_wait};

    assign wb_en   = done && in.we;
    assign wb_idx  = in.rd;
    assign wb_data = result;

    assign commit_valid = done;
    assign commit = '{pc: in.pc, inst: in.inst, wreg_en: in.we, wreg_idx: in.rd,
                      wdata: result, is_break: in.op == op_break};

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  rs1_idx,
    input  logic [4:0]  rs2_idx,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        wb_en,
    input  logic [4:0]  wb_idx,
    input  logic [31:0] wb_data
);
    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wb_en && wb_idx != 5'd0) begin
            regs[wb_idx] <= wb_data;
        end
    end

    // r0 reads as zero whatever was written
    assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

// File: logic/unified_memory.sv
`timescale 1ns/1ps

module unified_memory import core_pkg::*; #(
    parameter int mem_words = 1024
) (
    input  logic        clk,
    input  logic        mem_en,
    input  mem_req_t    mem_req,
    output logic [31:0] rdata
);
    localparam int aw = $clog2(mem_words);

    logic [31:0] mem [mem_words];
    logic [aw-1:0] idx;

    assign idx = mem_req.addr[aw-1:0];

    // single port with read data valid the cycle after
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_req.we)
                mem[idx] <= mem_req.wdata;
            else
                rdata <= mem[idx];
        end
    end

endmodule

// File: sources.f
logic/core_pkg.sv
logic/register_file.sv
logic/unified_memory.sv
logic/mem_arbiter.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/core_top.sv
verification/core_tb.sv

// File: verification/core_tb.sv
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();
    localparam int prog_words = 64;
    localparam int data_base  = 256;   // byte address 0x400
    localparam int data_words = 32;

    logic        clk;
    logic        arst_n;
    logic        run;
    logic        host_we;
    logic [31:0] host_addr;
    logic [31:0] host_wdata;
    commit_t     commit;
    logic        commit_valid;
    logic        halted;

    logic [31:0] model_mem [1024];
    logic [31:0] prog [$];
    commit_t     expected_q [$];
    commit_t     actual_q [$];
    int          seed;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    int          late_commits;
    bit          seen_break;
    bit          watch_on;
    int          watch_limit;
    int          watch_cycles;

    core_top #(.mem_words(1024), .reset_pc(32'h0)) UUT (
        .clk, .arst_n, .run, .host_we, .host_addr, .host_wdata,
        .commit, .commit_valid, .halted
    );

    always #50 clk = ~clk;

    // watchdog armed only while a program runs
    always @(posedge clk) begin
        if (!watch_on) begin
            watch_cycles = 0;
        end else if (watch_cycles >= watch_limit) begin
            $display("timeout: core did not halt within %0d cycles", watch_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            watch_cycles = watch_cycles + 1;
        end
    end

    // LoongArch encodings with rd in [4:0], rj in [9:5] and rk in [14:10]
    function automatic logic [31:0] add_w(input logic [4:0] rd, input logic [4:0] rj,
                                          input logic [4:0] rk);
        return {17'h00020, rk, rj, rd};
    endfunction

    function automatic logic [31:0] sub_w(input logic [4:0] rd, input logic [4:0] rj,
                                          input logic [4:0] rk);
        return {17'h00022, rk, rj, rd};
    endfunction

    function automatic logic [31:0] addi_w(input logic [4:0] rd, input logic [4:0] rj,
                                           input int imm);
        return {10'h00a, imm[11:0], rj, rd};
    endfunction

    function automatic logic [31:0] ld_w(input logic [4:0] rd, input logic [4:0] rj,
                                         input int imm);
        return {10'h0a2, imm[11:0], rj, rd};
    endfunction

    function automatic logic [31:0] st_w(input logic [4:0] rd, input logic [4:0] rj,
                                         input int imm);
        return {10'h0a6, imm[11:0], rj, rd};
    endfunction

    // offset counted in instructions
    function automatic logic [31:0] beq_off(input logic [4:0] rj, input logic [4:0] rd,
                                            input int off);
        return {6'h16, off[15:0], rj, rd};
    endfunction

    function automatic logic [31:0] bne_off(input logic [4:0] rj, input logic [4:0] rd,
                                            input int off);
        return {6'h17, off[15:0], rj, rd};
    endfunction

    function automatic logic [31:0] brk();
        return {17'h00054, 15'h0};
    endfunction

    function automatic logic [31:0] fill_word(input int word);
        return (32'(word) * 32'h0101_0101) ^ 32'h5ac3_e10f;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        arst_n  <= 1'b0;
        run     <= 1'b0;
        host_we <= 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic write_word(input int word, input logic [31:0] value);
        @(posedge clk);
        host_we    <= 1'b1;
        host_addr  <= 32'(word) << 2;
        host_wdata <= value;
    endtask

    task automatic load_memory();
        for (int i = 0; i < prog_words; i++)
            write_word(i, model_mem[i]);
        for (int i = data_base; i < data_base + data_words; i++)
            write_word(i, model_mem[i]);
        @(posedge clk);
        host_we <= 1'b0;
    endtask

    // architectural model that records one commit per executed instruction
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] si12;
        logic [31:0] offs;
        commit_t     c;
        bit          stop;
        int          steps;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        pc    = '0;
        stop  = 0;
        steps = 0;
        while (!stop && steps < 1000) begin
            inst       = model_mem[pc[11:2]];
            a          = regs[inst[9:5]];
            b          = regs[inst[4:0]];     // rd is a source for st and branches
            si12       = {{20{inst[21]}}, inst[21:10]};
            offs       = {{14{inst[25]}}, inst[25:10], 2'b00};
            next_pc    = pc + 32'd4;
            c          = '0;
            c.pc       = pc;
            c.inst     = inst;
            c.wreg_idx = inst[4:0];
            if (inst[31:15] == 17'h00020) begin
                c.wreg_en = 1'b1;
                c.wdata   = a + regs[inst[14:10]];
            end else if (inst[31:15] == 17'h00022) begin
                c.wreg_en = 1'b1;
                c.wdata   = a - regs[inst[14:10]];
            end else if (inst[31:15] == 17'h00054) begin
                c.is_break = 1'b1;
                stop       = 1;
            end else if (inst[31:22] == 10'h00a) begin
                c.wreg_en = 1'b1;
                c.wdata   = a + si12;
            end else if (inst[31:22] == 10'h0a2) begin
                c.wreg_en = 1'b1;
                c.wdata   = model_mem[(a + si12) >> 2 & 32'h3ff];
            end else if (inst[31:22] == 10'h0a6) begin
                model_mem[(a + si12) >> 2 & 32'h3ff] = b;
            end else if (inst[31:26] == 6'h16) begin
                if (a == b)
                    next_pc = pc + offs;
            end else if (inst[31:26] == 6'h17) begin
                if (a != b)
                    next_pc = pc + offs;
            end
            if (c.wreg_en && c.wreg_idx != 5'd0)
                regs[c.wreg_idx] = c.wdata;
            expected_q.push_back(c);
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic sample_commit();
        @(negedge clk);
        if (commit_valid) begin
            if (seen_break)
                late_commits++;
            actual_q.push_back(commit);
            if (commit.is_break)
                seen_break = 1;
        end
    endtask

    task automatic compare_commits(input string name);
        commit_t e;
        commit_t a;
        if (actual_q.size() != expected_q.size()) begin
            $display("FAIL %s commit count: expected %0d actual %0d", name,
                     expected_q.size(), actual_q.size());
            test_errors++;
        end
        for (int i = 0; i < expected_q.size() && i < actual_q.size(); i++) begin
            e = expected_q[i];
            a = actual_q[i];
            if (a.pc !== e.pc) begin
                $display("FAIL %s commit %0d pc: expected %h actual %h", name, i, e.pc, a.pc);
                test_errors++;
            end
            if (a.inst !== e.inst) begin
                $display("FAIL %s commit %0d inst: expected %h actual %h", name, i,
                         e.inst, a.inst);
                test_errors++;
            end
            if (a.wreg_en !== e.wreg_en || a.is_break !== e.is_break) begin
                $display("FAIL %s commit %0d flags: expected %b%b actual %b%b", name, i,
                         e.wreg_en, e.is_break, a.wreg_en, a.is_break);
                test_errors++;
            end
            if (e.wreg_en && a.wreg_idx !== e.wreg_idx) begin
                $display("FAIL %s commit %0d wreg_idx: expected %0d actual %0d", name, i,
                         e.wreg_idx, a.wreg_idx);
                test_errors++;
            end
            if (e.wreg_en && a.wdata !== e.wdata) begin
                $display("FAIL %s commit %0d wdata: expected %h actual %h", name, i,
                         e.wdata, a.wdata);
                test_errors++;
            end
        end
    endtask

    task automatic run_program(input string name);
        test_errors  = 0;
        late_commits = 0;
        seen_break   = 0;
        expected_q.delete();
        actual_q.delete();
        for (int i = 0; i < prog_words; i++)
            model_mem[i] = (i < prog.size()) ? prog[i] : 32'h0;
        for (int i = data_base; i < data_base + data_words; i++)
            model_mem[i] = fill_word(i);
        apply_reset();
        load_memory();
        run_model();
        watch_limit = 60 * prog.size();
        watch_on    = 1;
        @(posedge clk);
        run <= 1'b1;
        while (!halted)
            sample_commit();
        repeat (4) sample_commit();   // nothing may retire past the break
        watch_on = 0;
        compare_commits(name);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        total_errors += test_errors;
        $display("%s: %0d commits, %0d errors", name, actual_q.size(), test_errors);
    endtask

    task automatic alu_chain();
        prog.delete();
        prog.push_back(addi_w(1, 0, 5));
        prog.push_back(addi_w(2, 1, -3));    // from execute
        prog.push_back(add_w(3, 1, 2));      // both forward paths
        prog.push_back(sub_w(4, 3, 1));
        prog.push_back(add_w(5, 4, 4));
        prog.push_back(addi_w(1, 5, 100));
        prog.push_back(sub_w(6, 1, 2));
        prog.push_back(add_w(7, 6, 3));
        prog.push_back(brk());
        run_program("alu_chain");
        report_test("alu_chain");
    endtask

    task automatic load_store();
        prog.delete();
        prog.push_back(addi_w(1, 0, 1024));  // data region base
        prog.push_back(addi_w(2, 0, 77));
        prog.push_back(st_w(2, 1, 0));
        prog.push_back(st_w(1, 1, 4));
        prog.push_back(ld_w(3, 1, 0));
        prog.push_back(add_w(4, 3, 3));      // load-use
        prog.push_back(ld_w(5, 1, 8));       // untouched word still holds the fill
        prog.push_back(sub_w(6, 5, 3));
        prog.push_back(ld_w(7, 1, 4));
        prog.push_back(addi_w(8, 7, 1));
        prog.push_back(brk());
        run_program("load_store");
        report_test("load_store");
    endtask

    task automatic branch_paths();
        prog.delete();
        prog.push_back(addi_w(1, 0, 3));
        prog.push_back(addi_w(2, 0, 3));
        prog.push_back(beq_off(1, 2, 3));    // taken
        prog.push_back(addi_w(3, 0, 11));
        prog.push_back(addi_w(3, 0, 12));
        prog.push_back(bne_off(1, 2, 2));    // not taken
        prog.push_back(addi_w(4, 0, 21));
        prog.push_back(beq_off(1, 4, 2));    // not taken
        prog.push_back(bne_off(1, 4, 2));    // taken
        prog.push_back(addi_w(5, 0, 31));
        prog.push_back(addi_w(6, 0, 41));
        prog.push_back(brk());
        run_program("branch_paths");
        foreach (actual_q[i]) begin
            if (actual_q[i].pc inside {32'd12, 32'd16, 32'd36}) begin
                $display("branch_paths: wrong-path instruction at pc %h committed",
                         actual_q[i].pc);
                test_errors++;
            end
        end
        report_test("branch_paths");
    endtask

    task automatic zero_register();
        prog.delete();
        prog.push_back(addi_w(0, 0, 55));
        prog.push_back(add_w(1, 0, 0));      // must read zero
        prog.push_back(addi_w(2, 0, 7));
        prog.push_back(addi_w(0, 2, 9));
        prog.push_back(add_w(3, 0, 2));
        prog.push_back(brk());
        run_program("zero_register");
        if (actual_q.size() > 1 && actual_q[1].wdata !== 32'h0) begin
            $display("FAIL zero_register r1: expected %h actual %h", 32'h0, actual_q[1].wdata);
            test_errors++;
        end
        report_test("zero_register");
    endtask

    task automatic break_halt();
        prog.delete();
        prog.push_back(addi_w(1, 0, 1));
        prog.push_back(addi_w(2, 1, 2));
        prog.push_back(brk());
        prog.push_back(addi_w(3, 0, 99));    // never retires
        prog.push_back(add_w(4, 1, 2));
        run_program("break_halt");
        if (late_commits != 0) begin
            $display("break_halt: %0d instructions committed after break", late_commits);
            test_errors++;
        end
        if (!halted) begin
            $display("break_halt: halted dropped after the break committed");
            test_errors++;
        end
        report_test("break_halt");
    endtask

    task automatic random_loop();
        int rnd_a;
        int rnd_b;
        rnd_a = $random(seed);
        rnd_b = $random(seed);
        prog.delete();
        prog.push_back(addi_w(1, 0, rnd_a));
        prog.push_back(addi_w(2, 0, rnd_b));
        prog.push_back(addi_w(9, 0, 4));     // trip count
        prog.push_back(addi_w(10, 0, 1088));
        prog.push_back(add_w(3, 1, 2));      // loop head at pc 16
        prog.push_back(sub_w(4, 3, 1));
        prog.push_back(st_w(3, 10, 0));
        prog.push_back(st_w(4, 10, 4));
        prog.push_back(ld_w(1, 10, 4));
        prog.push_back(ld_w(5, 10, 0));
        prog.push_back(add_w(2, 5, 1));
        prog.push_back(addi_w(10, 10, 8));
        prog.push_back(addi_w(9, 9, -1));
        prog.push_back(bne_off(9, 0, -9));
        prog.push_back(brk());
        run_program("random_loop");
        report_test("random_loop");
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        run          = 1'b0;
        host_we      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        seed         = 54050;
        watch_on     = 0;
        watch_limit  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        alu_chain();
        load_store();
        branch_paths();
        zero_register();
        break_halt();
        random_loop();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
